/* Makefile */
# Verilator simulation of the core testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module core_tb -f vlog.f --Mdir $(OBJ_DIR) -o core_tb_sim
	./$(OBJ_DIR)/core_tb_sim | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath widths
`define CORE_XLEN       32
`define CORE_REG_AW     5
// Word address into the 64-word instruction memory
`define CORE_IMEM_AW    6

// Ring network
`define CORE_RING_ID_W  4
`define CORE_RING_ID    4'd3
`define CORE_NET_AW     16

// RV32 major opcodes of the reduced ISA
`define CORE_OP_OP      7'b0110011
`define CORE_OP_IMM     7'b0010011
`define CORE_OP_LUI     7'b0110111
`define CORE_OP_STORE   7'b0100011

// ALU funct3, SUB is ADD with funct7 bit 5 set
`define CORE_F3_ADD     3'b000
`define CORE_F3_XOR     3'b100
`define CORE_F3_OR      3'b110
`define CORE_F3_AND     3'b111

// Store size funct3
`define CORE_F3_SB      3'b000
`define CORE_F3_SH      3'b001
`define CORE_F3_SW      3'b010

// Packet command codes
`define CORE_NET_PC     2'd0
`define CORE_NET_INSTR  2'd1
`define CORE_NET_REG    2'd2

`endif

/* design/core_isa_pkg.sv */
`include "core_defs.svh"

package core_isa_pkg;

   // Register data, ALU operands and store data
   typedef logic [`CORE_XLEN-1:0]     word_t;

   // Index into the 32-entry register file
   typedef logic [`CORE_REG_AW-1:0]   reg_addr_t;

   // Raw RV32 instruction word
   typedef logic [31:0]               instr_t;

   // Word PC, also the imem address
   typedef logic [`CORE_IMEM_AW-1:0]  imem_addr_t;

   // One enable per byte lane of a data word
   typedef logic [`CORE_XLEN/8-1:0]   byte_mask_t;

endpackage

/* design/core_net_pkg.sv */
`include "core_defs.svh"

package core_net_pkg;

   // Ring ID carried by every packet
   typedef logic [`CORE_RING_ID_W-1:0]  ring_id_t;

   // Byte address field of a packet
   typedef logic [`CORE_NET_AW-1:0]     net_addr_t;

   // Packet command code
   typedef logic [1:0]                  net_op_t;

   // Core only executes after a PC command
   typedef enum logic
   {
      IDLE = 1'b0,
      RUN  = 1'b1
   } run_state_e;

endpackage

/* design/core_top.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top
#(
   parameter core_net_pkg::ring_id_t ring_id_p = `CORE_RING_ID
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      net_v_i,
   input  core_net_pkg::net_op_t     net_op_i,
   input  core_net_pkg::ring_id_t    net_ring_id_i,
   input  core_net_pkg::net_addr_t   net_addr_i,
   input  core_isa_pkg::word_t       net_data_i,
   input  logic                      mem_yumi_i,
   output logic                      mem_v_o,
   output core_isa_pkg::word_t       mem_addr_o,
   output core_isa_pkg::word_t       mem_data_o,
   output core_isa_pkg::byte_mask_t  mem_mask_o
);

   import core_isa_pkg::*;

   // Network side to fetch
   logic        imem_we;
   imem_addr_t  imem_waddr;
   instr_t      imem_wdata;
   logic        pc_set;
   imem_addr_t  pc_set_val;

   // Network side to pipeline
   logic        rf_we;
   reg_addr_t   rf_waddr;
   word_t       rf_wdata;
   logic        run;
   logic        net_busy;

   // Fetch and pipeline
   instr_t      instr;
   logic        stall;

   // Pipeline and store side
   logic        exe_store;
   word_t       st_addr;
   word_t       st_data;
   logic [1:0]  st_size;
   logic        store_wait;

   net_cmd_unit #(.ring_id_p(ring_id_p)) net_cmd_i
   (
      .clk           (clk),
      .reset         (reset),
      .net_v_i       (net_v_i),
      .net_op_i      (net_op_i),
      .net_ring_id_i (net_ring_id_i),
      .net_addr_i    (net_addr_i),
      .net_data_i    (net_data_i),
      .imem_we_o     (imem_we),
      .imem_waddr_o  (imem_waddr),
      .imem_wdata_o  (imem_wdata),
      .pc_set_o      (pc_set),
      .pc_set_val_o  (pc_set_val),
      .rf_we_o       (rf_we),
      .rf_waddr_o    (rf_waddr),
      .rf_wdata_o    (rf_wdata),
      .run_o         (run),
      .net_busy_o    (net_busy)
   );

   fetch_unit fetch_i
   (
      .clk           (clk),
      .reset         (reset),
      .imem_we_i     (imem_we),
      .imem_waddr_i  (imem_waddr),
      .imem_wdata_i  (imem_wdata),
      .pc_set_i      (pc_set),
      .pc_set_val_i  (pc_set_val),
      .stall_i       (stall),
      .instr_o       (instr)
   );

   exec_pipeline exec_i
   (
      .clk           (clk),
      .reset         (reset),
      .instr_i       (instr),
      .rf_we_i       (rf_we),
      .rf_waddr_i    (rf_waddr),
      .rf_wdata_i    (rf_wdata),
      .run_i         (run),
      .net_busy_i    (net_busy),
      .store_wait_i  (store_wait),
      .stall_o       (stall),
      .exe_store_o   (exe_store),
      .st_addr_o     (st_addr),
      .st_data_o     (st_data),
      .st_size_o     (st_size)
   );

   store_port store_i
   (
      .exe_store_i   (exe_store),
      .st_addr_i     (st_addr),
      .st_data_i     (st_data),
      .st_size_i     (st_size),
      .mem_yumi_i    (mem_yumi_i),
      .mem_v_o       (mem_v_o),
      .mem_addr_o    (mem_addr_o),
      .mem_data_o    (mem_data_o),
      .mem_mask_o    (mem_mask_o),
      .store_wait_o  (store_wait)
   );

endmodule

/* design/exec_pipeline.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module exec_pipeline
(
   input  logic                      clk,
   input  logic                      reset,
   input  core_isa_pkg::instr_t      instr_i,
   input  logic                      rf_we_i,
   input  core_isa_pkg::reg_addr_t   rf_waddr_i,
   input  core_isa_pkg::word_t       rf_wdata_i,
   input  logic                      run_i,
   input  logic                      net_busy_i,
   input  logic                      store_wait_i,
   output logic                      stall_o,
   output logic                      exe_store_o,
   output core_isa_pkg::word_t       st_addr_o,
   output core_isa_pkg::word_t       st_data_o,
   output logic [1:0]                st_size_o
);

   import core_isa_pkg::*;

   // ALU operation codes
   localparam logic [2:0] ALU_ADD = 3'd0;
   localparam logic [2:0] ALU_SUB = 3'd1;
   localparam logic [2:0] ALU_AND = 3'd2;
   localparam logic [2:0] ALU_OR  = 3'd3;
   localparam logic [2:0] ALU_XOR = 3'd4;

   logic        stall;
   logic        stage_clear;

   // ID stage and decode
   instr_t      id_instr;
   reg_addr_t   id_rs1, id_rs2, id_rd;
   logic        dec_writes, dec_reads1, dec_reads2, dec_store, dec_use_imm;
   logic [2:0]  dec_alu_op;
   word_t       dec_imm;
   word_t       id_rs1_val, id_rs2_val;
   logic        id_rs1_fwd, id_rs2_fwd;

   // EXE stage
   logic        exe_writes, exe_reads1, exe_reads2, exe_store, exe_use_imm;
   logic [2:0]  exe_alu_op;
   logic [1:0]  exe_size;
   reg_addr_t   exe_rd, exe_rs1, exe_rs2;
   word_t       exe_rs1_val, exe_rs2_val, exe_imm;
   logic        exe_rs1_fwd, exe_rs2_fwd;
   word_t       rs1_to_alu, rs2_to_alu, alu_b, alu_result;

   // WB stage
   logic        wb_writes;
   reg_addr_t   wb_rd;
   word_t       wb_data;

   // Register file
   word_t       rf_mem [1 << `CORE_REG_AW];
   logic        rf_wen;
   reg_addr_t   rf_wa;
   word_t       rf_wd;

   // Nothing moves while idle, loading memories, or waiting on a store
   assign stall   = ~run_i | net_busy_i | store_wait_i;
   assign stall_o = stall;

   // Stages stay empty until the PC command starts the core
   assign stage_clear = reset | ~run_i;

   //////////////////////////////////////////////////////////////////////
   // Decode

   assign id_rs1 = id_instr[19:15];
   assign id_rs2 = id_instr[24:20];
   assign id_rd  = id_instr[11:7];

   always_comb
   begin
      dec_writes  = 1'b0;
      dec_reads1  = 1'b0;
      dec_reads2  = 1'b0;
      dec_store   = 1'b0;
      dec_use_imm = 1'b0;
      dec_alu_op  = ALU_ADD;
      dec_imm     = '0;
      case (id_instr[6:0])
         `CORE_OP_OP:
         begin
            dec_writes = 1'b1;
            dec_reads1 = 1'b1;
            dec_reads2 = 1'b1;
            case (id_instr[14:12])
               // funct7 bit 5 selects SUB
               `CORE_F3_ADD: dec_alu_op = id_instr[30] ? ALU_SUB : ALU_ADD;
               `CORE_F3_XOR: dec_alu_op = ALU_XOR;
               `CORE_F3_OR:  dec_alu_op = ALU_OR;
               `CORE_F3_AND: dec_alu_op = ALU_AND;
               default:      dec_writes = 1'b0;
            endcase
         end
         `CORE_OP_IMM:
         begin
            // ADDI only
            dec_writes  = (id_instr[14:12] == `CORE_F3_ADD);
            dec_reads1  = 1'b1;
            dec_use_imm = 1'b1;
            dec_imm     = {{20{id_instr[31]}}, id_instr[31:20]};
         end
         `CORE_OP_LUI:
         begin
            // Zero plus the U-immediate
            dec_writes  = 1'b1;
            dec_use_imm = 1'b1;
            dec_imm     = {id_instr[31:12], 12'b0};
         end
         `CORE_OP_STORE:
         begin
            dec_store   = (id_instr[14:12] == `CORE_F3_SB)
                        | (id_instr[14:12] == `CORE_F3_SH)
                        | (id_instr[14:12] == `CORE_F3_SW);
            dec_reads1  = 1'b1;
            dec_reads2  = 1'b1;
            dec_use_imm = 1'b1;
            dec_imm     = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
         end
         default:
         begin
            dec_writes = 1'b0;
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Register file

   // Network write has priority, WB writes only when the pipe advances
   assign rf_wen = rf_we_i | (wb_writes & ~stall);
   assign rf_wa  = rf_we_i ? rf_waddr_i : wb_rd;
   assign rf_wd  = rf_we_i ? rf_wdata_i : wb_data;

   always_ff @(posedge clk)
   begin
      if (rf_wen)
      begin
         rf_mem[rf_wa] <= rf_wd;
      end
   end

   // WB result not yet in the array, write-through bypass
   assign id_rs1_fwd = wb_writes & (wb_rd == id_rs1);
   assign id_rs2_fwd = wb_writes & (wb_rd == id_rs2);

   // x0 and unused sources read as zero
   assign id_rs1_val = (~dec_reads1 | (id_rs1 == '0)) ? '0
                     : id_rs1_fwd ? wb_data : rf_mem[id_rs1];
   assign id_rs2_val = (~dec_reads2 | (id_rs2 == '0)) ? '0
                     : id_rs2_fwd ? wb_data : rf_mem[id_rs2];

   //////////////////////////////////////////////////////////////////////
   // Stage registers

   always_ff @(posedge clk)
   begin
      if (stage_clear)
      begin
         id_instr   <= '0;
         exe_writes <= 1'b0;
         exe_reads1 <= 1'b0;
         exe_reads2 <= 1'b0;
         exe_store  <= 1'b0;
         wb_writes  <= 1'b0;
      end
      else if (~stall)
      begin
         id_instr   <= instr_i;
         exe_writes <= dec_writes;
         exe_reads1 <= dec_reads1;
         exe_reads2 <= dec_reads2;
         exe_store  <= dec_store;
         wb_writes  <= exe_writes;
      end
   end

   // Operands and results, only meaningful under the flags above
   always_ff @(posedge clk)
   begin
      if (~stall)
      begin
         exe_alu_op  <= dec_alu_op;
         exe_use_imm <= dec_use_imm;
         exe_imm     <= dec_imm;
         exe_size    <= id_instr[13:12];
         exe_rd      <= id_rd;
         exe_rs1     <= id_rs1;
         exe_rs2     <= id_rs2;
         exe_rs1_val <= id_rs1_val;
         exe_rs2_val <= id_rs2_val;
         wb_rd       <= exe_rd;
         wb_data     <= alu_result;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Execute

   // Previous instruction sits in WB, never forward x0
   assign exe_rs1_fwd = exe_reads1 & wb_writes & (wb_rd == exe_rs1) & (exe_rs1 != '0);
   assign exe_rs2_fwd = exe_reads2 & wb_writes & (wb_rd == exe_rs2) & (exe_rs2 != '0);

   assign rs1_to_alu = exe_rs1_fwd ? wb_data : exe_rs1_val;
   assign rs2_to_alu = exe_rs2_fwd ? wb_data : exe_rs2_val;
   assign alu_b      = exe_use_imm ? exe_imm : rs2_to_alu;

   always_comb
   begin
      case (exe_alu_op)
         ALU_SUB: alu_result = rs1_to_alu - alu_b;
         ALU_AND: alu_result = rs1_to_alu & alu_b;
         ALU_OR:  alu_result = rs1_to_alu | alu_b;
         ALU_XOR: alu_result = rs1_to_alu ^ alu_b;
         default: alu_result = rs1_to_alu + alu_b;
      endcase
   end

   // Stores use the adder for rs1 plus S-immediate
   assign exe_store_o = exe_store;
   assign st_addr_o   = alu_result;
   assign st_data_o   = rs2_to_alu;
   assign st_size_o   = exe_size;

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_unit
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      imem_we_i,
   input  core_isa_pkg::imem_addr_t  imem_waddr_i,
   input  core_isa_pkg::instr_t      imem_wdata_i,
   input  logic                      pc_set_i,
   input  core_isa_pkg::imem_addr_t  pc_set_val_i,
   input  logic                      stall_i,
   output core_isa_pkg::instr_t      instr_o
);

   import core_isa_pkg::*;

   imem_addr_t  pc_r;
   imem_addr_t  pc_n;
   logic        pc_wen;
   logic        pc_wen_r;

   instr_t      imem_mem [1 << `CORE_IMEM_AW];
   instr_t      imem_rdata;
   instr_t      instr_held;

   // Network set wins over a stall
   assign pc_wen = pc_set_i | ~stall_i;

   // Word PC, so increment by one
   assign pc_n = pc_set_i ? pc_set_val_i : imem_addr_t'(pc_r + 1'b1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pc_r     <= '0;
         pc_wen_r <= 1'b0;
      end
      else
      begin
         pc_wen_r <= pc_wen;
         if (pc_wen)
         begin
            pc_r <= pc_n;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Instruction memory

   // Network write port, synchronous read of the next PC
   always_ff @(posedge clk)
   begin
      if (imem_we_i)
      begin
         imem_mem[imem_waddr_i] <= imem_wdata_i;
      end
      imem_rdata <= imem_mem[pc_n];
   end

   // Read data belongs to a PC that did not advance
   // so replay the last instruction instead
   assign instr_o = pc_wen_r ? imem_rdata : instr_held;

   always_ff @(posedge clk)
   begin
      instr_held <= instr_o;
   end

endmodule

/* design/net_cmd_unit.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module net_cmd_unit
#(
   parameter core_net_pkg::ring_id_t ring_id_p = `CORE_RING_ID
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      net_v_i,
   input  core_net_pkg::net_op_t     net_op_i,
   input  core_net_pkg::ring_id_t    net_ring_id_i,
   input  core_net_pkg::net_addr_t   net_addr_i,
   input  core_isa_pkg::word_t       net_data_i,
   output logic                      imem_we_o,
   output core_isa_pkg::imem_addr_t  imem_waddr_o,
   output core_isa_pkg::instr_t      imem_wdata_o,
   output logic                      pc_set_o,
   output core_isa_pkg::imem_addr_t  pc_set_val_o,
   output logic                      rf_we_o,
   output core_isa_pkg::reg_addr_t   rf_waddr_o,
   output core_isa_pkg::word_t       rf_wdata_o,
   output logic                      run_o,
   output logic                      net_busy_o
);

   import core_isa_pkg::*;
   import core_net_pkg::*;

   // Registered packet
   logic        net_v_r;
   net_op_t     net_op_r;
   ring_id_t    net_ring_id_r;
   net_addr_t   net_addr_r;
   word_t       net_data_r;

   run_state_e  state_r;
   run_state_e  state_n;

   logic        net_exec;
   logic        pc_cmd;
   logic        instr_cmd;
   logic        reg_cmd;

   // Only the valid bit is control state
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         net_v_r <= 1'b0;
      end
      else
      begin
         net_v_r <= net_v_i;
      end
   end

   always_ff @(posedge clk)
   begin
      net_op_r      <= net_op_i;
      net_ring_id_r <= net_ring_id_i;
      net_addr_r    <= net_addr_i;
      net_data_r    <= net_data_i;
   end

   //////////////////////////////////////////////////////////////////////
   // Command decode

   // Packet is for this core
   assign net_exec  = net_v_r & (net_ring_id_r == ring_id_p);

   assign instr_cmd = net_exec & (net_op_r == `CORE_NET_INSTR);
   assign reg_cmd   = net_exec & (net_op_r == `CORE_NET_REG);
   // PC writes are ignored once running
   assign pc_cmd    = net_exec & (net_op_r == `CORE_NET_PC) & (state_r == IDLE);

   // Byte address to word address
   assign imem_we_o    = instr_cmd;
   assign imem_waddr_o = net_addr_r[2 +: `CORE_IMEM_AW];
   assign imem_wdata_o = net_data_r;

   assign pc_set_o     = pc_cmd;
   assign pc_set_val_o = net_addr_r[2 +: `CORE_IMEM_AW];

   // Register index from the low address bits
   assign rf_we_o      = reg_cmd;
   assign rf_waddr_o   = net_addr_r[`CORE_REG_AW-1:0];
   assign rf_wdata_o   = net_data_r;

   // Pipeline holds while memories are written
   assign net_busy_o   = instr_cmd | reg_cmd;

   //////////////////////////////////////////////////////////////////////
   // IDLE/RUN state machine

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         IDLE:
         begin
            if (pc_cmd)
            begin
               state_n = RUN;
            end
         end
         // No halt, RUN is final
         RUN:     state_n = RUN;
         default: state_n = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_r <= IDLE;
      end
      else
      begin
         state_r <= state_n;
      end
   end

   assign run_o = (state_r == RUN);

endmodule

/* design/store_port.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module store_port
(
   input  logic                      exe_store_i,
   input  core_isa_pkg::word_t       st_addr_i,
   input  core_isa_pkg::word_t       st_data_i,
   input  logic [1:0]                st_size_i,
   input  logic                      mem_yumi_i,
   output logic                      mem_v_o,
   output core_isa_pkg::word_t       mem_addr_o,
   output core_isa_pkg::word_t       mem_data_o,
   output core_isa_pkg::byte_mask_t  mem_mask_o,
   output logic                      store_wait_o
);

   import core_isa_pkg::*;

   logic [4:0]  lane_shift;
   word_t       byte_data;
   word_t       half_data;

   // Byte offset times eight
   assign lane_shift = {st_addr_i[1:0], 3'b000};

   assign byte_data  = word_t'(st_data_i[7:0]) << lane_shift;
   assign half_data  = word_t'(st_data_i[15:0]) << lane_shift;

   always_comb
   begin
      case ({1'b0, st_size_i})
         `CORE_F3_SB:
         begin
            mem_data_o = byte_data;
            mem_mask_o = byte_mask_t'(4'b0001) << st_addr_i[1:0];
         end
         `CORE_F3_SH:
         begin
            mem_data_o = half_data;
            mem_mask_o = byte_mask_t'(4'b0011) << st_addr_i[1:0];
         end
         default:
         begin
            mem_data_o = st_data_i;
            mem_mask_o = '1;
         end
      endcase
   end

   // EXE registers hold while waiting, so the request stays stable
   assign mem_v_o      = exe_store_i;
   assign mem_addr_o   = st_addr_i;
   assign store_wait_o = exe_store_i & ~mem_yumi_i;

endmodule

/* dv/core_assertions.sv */
`timescale 1ns/1ps

module core_assertions
(
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      mem_v_i,
   input  logic                      mem_yumi_i,
   input  core_isa_pkg::word_t       mem_addr_i,
   input  core_isa_pkg::word_t       mem_data_i,
   input  core_isa_pkg::byte_mask_t  mem_mask_i
);

   //////////////////////////////////////////////////////////////////////
   // Store request rules

   // A pending store keeps its request until memory takes it
   store_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
      (mem_v_i && !mem_yumi_i) |=> (mem_v_i && $stable(mem_addr_i)
                                    && $stable(mem_data_i) && $stable(mem_mask_i)))
      else $error("store request changed before memory accepted it");

   // Byte, half or word mask shifted to its lane
   mask_legal_a: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_v_i |-> (mem_mask_i inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                      4'b0011, 4'b0110, 4'b1100, 4'b1111}))
      else $error("illegal store byte mask %b", mem_mask_i);

   // Stages are cleared by reset, so no store right after it
   reset_quiet_a: assert property (@(posedge clk_i)
      reset_i |=> !mem_v_i)
      else $error("store request during reset");

endmodule

/* dv/core_stim.txt */
# P op ring_id byte_addr data (hex): op 0 sets the PC, 1 writes imem, 2 writes a register
# E addr data mask (hex): expected store, in program order
P 2 3 0001 00001000
P 2 3 0002 deadbeef
P 2 3 0003 12345678
P 2 5 0003 ffffffff
P 1 3 0000 0020a023
P 1 3 0004 0030a223
P 1 3 0008 12300213
P 1 3 000c 004202b3
P 1 3 0010 40228333
P 1 3 0014 003373b3
P 1 3 0018 0053e433
P 1 3 001c 006444b3
P 1 3 0020 0090a423
P 1 3 0024 abcde537
P 1 3 0028 01250513
P 1 3 002c 00a0a623
P 1 3 0030 00500013
P 1 3 0034 0000a823
P 1 3 0038 0a500613
P 1 3 003c 02108693
P 1 3 0040 00c68023
P 1 3 0044 02309123
P 1 3 0048 022089a3
P 1 3 004c 04809023
P 0 3 0000 00000000
E 00001000 deadbeef f
E 00001004 12345678 f
E 00001008 21420101 f
E 0000100c abcde012 f
E 00001010 00000000 f
E 00001021 0000a500 2
E 00001022 56780000 c
E 00001033 ef000000 8
E 00001040 00004256 3

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

   import core_isa_pkg::*;
   import core_net_pkg::*;

   localparam string       STIM_FILE         = "dv/core_stim.txt";
   localparam int          RESET_CYCLES      = 4;
   localparam int          CYCLES_PER_RECORD = 200;
   // Much shorter than the PC needs to wrap back into the program
   localparam int          DRAIN_CYCLES      = 16;
   localparam logic [31:0] LFSR_SEED         = 32'hc163_b145;
   localparam logic [31:0] LFSR_TAPS         = 32'hd000_0001;

   logic        clk;
   logic        reset;
   logic        net_v;
   net_op_t     net_op;
   ring_id_t    net_ring_id;
   net_addr_t   net_addr;
   word_t       net_data;
   logic        mem_yumi;
   logic        mem_v;
   word_t       mem_addr;
   word_t       mem_data;
   byte_mask_t  mem_mask;

   // Packet records in file order
   net_op_t     pkt_op_q [$];
   ring_id_t    pkt_ring_q [$];
   net_addr_t   pkt_addr_q [$];
   word_t       pkt_data_q [$];
   // Expected stores in program order
   word_t       exp_addr_q [$];
   word_t       exp_data_q [$];
   byte_mask_t  exp_mask_q [$];

   int          exp_total;
   int          record_count;
   int          store_count;
   logic        loading;
   logic        stim_ready;
   logic [31:0] lfsr_state;

   always
   begin
      #2 clk = ~clk;
   end

   core_top dut_i
   (
      .clk           (clk),
      .reset         (reset),
      .net_v_i       (net_v),
      .net_op_i      (net_op),
      .net_ring_id_i (net_ring_id),
      .net_addr_i    (net_addr),
      .net_data_i    (net_data),
      .mem_yumi_i    (mem_yumi),
      .mem_v_o       (mem_v),
      .mem_addr_o    (mem_addr),
      .mem_data_o    (mem_data),
      .mem_mask_o    (mem_mask)
   );

   bind store_port core_assertions store_checks_i
   (
      .clk_i      (core_tb.clk),
      .reset_i    (core_tb.reset),
      .mem_v_i    (mem_v_o),
      .mem_yumi_i (mem_yumi_i),
      .mem_addr_i (mem_addr_o),
      .mem_data_i (mem_data_o),
      .mem_mask_i (mem_mask_o)
   );

   //////////////////////////////////////////////////////////////////////
   // Helpers

   // Right-shifting Galois form with one step per bit used
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0])
      begin
         next = next ^ LFSR_TAPS;
      end
      return next;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      if (expected !== actual)
      begin
         report_failure($sformatf("Error: %s expected %h actual %h", name, expected, actual));
      end
   endtask

   // P lines hold packets and E lines expected stores
   // Any other line is skipped
   task automatic read_stim();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f0, f1, f2, f3;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0)
      begin
         report_failure({"Cannot open stimulus file ", STIM_FILE});
      end
      else
      begin
         while ($fgets(line, fd) > 0)
         begin
            if (line.getc(0) == "P")
            begin
               n = $sscanf(line, "P %h %h %h %h", f0, f1, f2, f3);
               if (n != 4)
               begin
                  report_failure({"Malformed packet record: ", line});
               end
               pkt_op_q.push_back(net_op_t'(f0));
               pkt_ring_q.push_back(ring_id_t'(f1));
               pkt_addr_q.push_back(net_addr_t'(f2));
               pkt_data_q.push_back(f3);
            end
            else if (line.getc(0) == "E")
            begin
               n = $sscanf(line, "E %h %h %h", f0, f1, f2);
               if (n != 3)
               begin
                  report_failure({"Malformed store record: ", line});
               end
               exp_addr_q.push_back(f0);
               exp_data_q.push_back(f1);
               exp_mask_q.push_back(byte_mask_t'(f2));
            end
         end
         $fclose(fd);
      end
   endtask

   // One packet per cycle with the PC command as the last record
   task automatic send_packets();
      int i;
      for (i = 0; i < pkt_op_q.size(); i++)
      begin
         @(posedge clk);
         net_v       <= 1'b1;
         net_op      <= pkt_op_q[i];
         net_ring_id <= pkt_ring_q[i];
         net_addr    <= pkt_addr_q[i];
         net_data    <= pkt_data_q[i];
      end
      @(posedge clk);
      net_v <= 1'b0;
   endtask

   task automatic check_store();
      string tag;
      if (store_count >= exp_total)
      begin
         report_failure($sformatf("Extra store to address %h after the last expected one",
                                  mem_addr));
      end
      else
      begin
         tag = $sformatf("store %0d", store_count);
         check_value({tag, " address"}, exp_addr_q[store_count], mem_addr);
         check_value({tag, " data"}, exp_data_q[store_count], mem_data);
         check_value({tag, " mask"}, word_t'(exp_mask_q[store_count]), word_t'(mem_mask));
         store_count++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Memory back-pressure and store monitor

   always @(posedge clk)
   begin
      if (reset)
      begin
         mem_yumi   <= 1'b0;
         lfsr_state <= LFSR_SEED;
      end
      else
      begin
         mem_yumi   <= lfsr_state[0];
         lfsr_state <= lfsr_next(lfsr_state);
      end
   end

   // Sampled mid-cycle since the handshake completes at the next rising edge
   always @(negedge clk)
   begin
      if (!reset && mem_v)
      begin
         if (loading)
         begin
            report_failure("Store request seen while packets were still loading");
         end
         else if (mem_yumi)
         begin
            check_store();
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      net_v       = 1'b0;
      net_op      = '0;
      net_ring_id = '0;
      net_addr    = '0;
      net_data    = '0;
      mem_yumi    = 1'b0;
      loading     = 1'b1;
      stim_ready  = 1'b0;
      store_count = 0;
      read_stim();
      exp_total    = exp_addr_q.size();
      record_count = pkt_op_q.size() + exp_total;
      stim_ready   = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      send_packets();
      loading <= 1'b0;
      // Every expected store has to arrive before the watchdog fires
      wait (store_count == exp_total);
      // Quiet window catches a duplicated store
      repeat (DRAIN_CYCLES) @(posedge clk);
      $display("Finished with no errors");
      $finish;
   end

   initial
   begin
      wait (stim_ready);
      repeat (record_count * CYCLES_PER_RECORD) @(posedge clk);
      report_failure($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                               record_count * CYCLES_PER_RECORD, store_count, exp_total));
   end

endmodule

/* vlog.f */
+incdir+design
design/core_isa_pkg.sv
design/core_net_pkg.sv
design/net_cmd_unit.sv
design/fetch_unit.sv
design/exec_pipeline.sv
design/store_port.sv
design/core_top.sv
dv/core_assertions.sv
dv/core_tb.sv
